// ==== tb/router_switch_vectors.txt ====
# Columns are in_n in_s in_w in_e in_l advance exp_n exp_s exp_w exp_e exp_l exp_served
# A flit is 5 hex digits {valid, dest[2:0], payload[15:0]} and served has one bit per input
# Idle
00000 00000 00000 00000 00000 0 00000 00000 00000 00000 00000 00
# Single routes
B1234 00000 00000 00000 00000 0 00000 00000 00000 B1234 00000 01
00000 00000 00000 00000 9ABCD 0 00000 9ABCD 00000 00000 00000 10
00000 00000 CBEEF 00000 00000 0 00000 00000 00000 00000 CBEEF 04
# U-turns, bad addresses and a flit without valid
14444 91111 F3333 D2222 00000 0 00000 00000 00000 00000 00000 00
00000 00000 00000 00000 C5555 0 00000 00000 00000 00000 00000 00
# Contention at N with advance low
00000 8A001 8A002 8A003 8A004 0 8A001 00000 00000 00000 00000 02
00000 8A001 8A002 8A003 8A004 0 8A001 00000 00000 00000 00000 02
00000 00000 8B002 8B003 8B004 0 8B002 00000 00000 00000 00000 04
# Rotation at N with advance high
00000 8C001 8C002 8C003 8C004 1 8C001 00000 00000 00000 00000 02
00000 8C001 8C002 8C003 8C004 1 8C002 00000 00000 00000 00000 04
00000 8C001 8C002 8C003 8C004 1 8C003 00000 00000 00000 00000 08
00000 8C001 8C002 8C003 8C004 1 8C004 00000 00000 00000 00000 10
00000 8C001 8C002 8C003 8C004 1 8C001 00000 00000 00000 00000 02
00000 8D001 00000 00000 8D004 1 8D004 00000 00000 00000 00000 10
00000 8D001 00000 00000 8D004 0 8D001 00000 00000 00000 00000 02
00000 8D001 00000 00000 8D004 0 8D001 00000 00000 00000 00000 02
# Rotation at L, then an idle advance that leaves the pointer alone
CE000 00000 00000 CE003 00000 1 00000 00000 00000 00000 CE000 01
CE000 00000 00000 CE003 00000 1 00000 00000 00000 00000 CE003 08
CE000 00000 00000 CE003 00000 1 00000 00000 00000 00000 CE000 01
00000 00000 00000 00000 00000 1 00000 00000 00000 00000 00000 00
CF000 00000 00000 CF003 00000 0 00000 00000 00000 00000 CF003 08
# Parallel outputs
90A00 80A01 B0A02 A0A03 00000 0 80A01 90A00 A0A03 B0A02 00000 0F
C0B00 A0B01 80B02 90B03 B0B04 1 80B02 90B03 A0B01 B0B04 C0B00 1F
B0C00 B0C01 80C02 80C03 90C04 0 80C03 90C04 00000 B0C00 00000 19
# Drain
00000 00000 00000 00000 00000 0 00000 00000 00000 00000 00000 00

// ==== compile.f ====
common/noc_pkg.sv
design/route_decoder.sv
rr_arbiter/rr_arbiter.sv
design/crossbar_switch.sv
design/noc_router_switch.sv
tb/clk_gen.sv
tb/router_switch_props.sv
tb/router_switch_tb.sv

// ==== Bender.yml ====
package:
  name: noc_router_switch

sources:
  - common/noc_pkg.sv
  - design/route_decoder.sv
  - rr_arbiter/rr_arbiter.sv
  - design/crossbar_switch.sv
  - design/noc_router_switch.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/router_switch_props.sv
      - tb/router_switch_tb.sv

// ==== tb/router_switch_tb.sv ====
`timescale 1ns/1ps

module router_switch_tb
        import noc_pkg::*;
();

        typedef struct packed {
                flit_arr_t in_flit;
                logic      advance;
                flit_arr_t exp_flit;
                req_vec_t  exp_served;
        } vector_t;

        localparam string VEC_FILE  = "tb/router_switch_vectors.txt";
        localparam time   DRIVE_DLY = 1ns;
        localparam int    SLACK     = 20; // Cycles allowed beyond the vector count

        logic        clk;
        logic        rst_n;
        flit_arr_t   in_flit;
        logic        order_advance;
        flit_arr_t   out_flit;
        req_vec_t    in_served;
        vector_t     vecs[$];
        int unsigned cycle_cnt   = 0;
        int unsigned cycle_limit = 0;

        clk_gen clk_gen_i (
                .clk_o   (clk),
                .rst_n_o (rst_n)
        );

        noc_router_switch dut_i (
                .clk             (clk),
                .rst_n_i         (rst_n),
                .in_flit_i       (in_flit),
                .order_advance_i (order_advance),
                .out_flit_o      (out_flit),
                .in_served_o     (in_served)
        );

        // ############################################################
        // Failure handling and compare tasks
        // ############################################################

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1);
        endtask

        task automatic check_flit(input string name, input flit_t got, input flit_t exp);
                if (got !== exp) begin
                        abort_run($sformatf("ERR %s: got 0x%05h, expected 0x%05h",
                                name, got, exp));
                end
        endtask

        task automatic check_served(input req_vec_t got, input req_vec_t exp);
                if (got !== exp) begin
                        abort_run($sformatf("ERR in_served_o: got 0x%02h, expected 0x%02h",
                                got, exp));
                end
        endtask

        task automatic check_props();
                if (dut_i.props_i.assert_fails != 0) begin
                        abort_run("A bound assertion on the DUT failed");
                end
        endtask

        // ############################################################
        // Vector file
        // ############################################################

        task automatic load_vectors();
                int       fd;
                int       n;
                string    line;
                flit_t    fin  [NUM_PORTS];
                flit_t    fexp [NUM_PORTS];
                logic     adv;
                req_vec_t srv;
                vector_t  v;
                fd = $fopen(VEC_FILE, "r");
                if (fd == 0) begin
                        abort_run({"Could not open the vector file ", VEC_FILE});
                end
                while (!$feof(fd)) begin
                        line = "";
                        void'($fgets(line, fd));
                        if (line.len() < 2 || line[0] == "#") begin
                                continue; // Comment or blank line
                        end
                        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                fin[0], fin[1], fin[2], fin[3], fin[4], adv,
                                fexp[0], fexp[1], fexp[2], fexp[3], fexp[4], srv);
                        if (n != 12) begin
                                abort_run({"Malformed line in the vector file: ", line});
                        end
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                v.in_flit[p]  = fin[p];
                                v.exp_flit[p] = fexp[p];
                        end
                        v.advance    = adv;
                        v.exp_served = srv;
                        vecs.push_back(v);
                end
                $fclose(fd);
        endtask

        always @(posedge clk) begin
                if (cycle_limit != 0) begin
                        cycle_cnt++;
                        if (cycle_cnt >= cycle_limit) begin
                                abort_run("The run did not finish before the cycle limit");
                        end
                end
        end

        // ############################################################
        // Main sequence
        // ############################################################

        initial begin
                in_flit       = '0;
                order_advance = 1'b0;
                load_vectors();
                cycle_limit = vecs.size() + SLACK;
                wait (rst_n === 1'b1);
                for (int o = 0; o < NUM_PORTS; o++) begin
                        check_flit($sformatf("out_flit_o[%0d]", o), out_flit[o], '0);
                end
                check_served(in_served, '0);
                foreach (vecs[k]) begin
                        in_flit       = vecs[k].in_flit; // One vector per clock cycle
                        order_advance = vecs[k].advance;
                        @(posedge clk);
                        #DRIVE_DLY;
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                check_flit($sformatf("out_flit_o[%0d]", o), out_flit[o],
                                        vecs[k].exp_flit[o]);
                        end
                        check_served(in_served, vecs[k].exp_served);
                        check_props();
                end
                if (dut_i.props_i.assert_fails == 0) begin
                        $display("Test passed");
                        $finish;
                end else begin
                        abort_run("A bound assertion on the DUT failed");
                end
        end

endmodule

// ==== tb/router_switch_props.sv ====
`timescale 1ns/1ps

module router_switch_props
        import noc_pkg::*;
(
        input logic      clk,
        input logic      rst_n_i,
        input req_mat_t  req_mat_i,
        input req_mat_t  grant_mat_i,
        input flit_arr_t out_flit_i
);

        int unsigned assert_fails = 0; // Read by the testbench after each cycle
        req_vec_t    out_vld;

        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        out_vld[o] = out_flit_i[o].valid;
                end
        end

        // ############################################################
        // Grant checks per output port
        // ############################################################

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
                a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
                        $onehot0(grant_mat_i[o]))
                else begin
                        assert_fails++;
                        $error("Output %0d granted more than one input", o);
                end

                a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n_i)
                        (grant_mat_i[o] & ~req_mat_i[o]) == '0)
                else begin
                        assert_fails++;
                        $error("Output %0d granted an input that did not request", o);
                end
        end

        a_reset_clears: assert property (@(posedge clk) !rst_n_i |=> (out_vld == '0))
        else begin
                assert_fails++;
                $error("An output stayed valid after reset");
        end

endmodule

bind noc_router_switch router_switch_props props_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_mat_i   (req_mat),
        .grant_mat_i (grant_mat),
        .out_flit_i  (out_flit_o)
);

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
        output logic clk_o,
        output logic rst_n_o
);

        localparam time HALF_PERIOD = 10ns; // 20 ns clock

        initial begin
                clk_o = 1'b0;
                forever #HALF_PERIOD clk_o = ~clk_o;
        end

        initial begin
                rst_n_o = 1'b0;
                repeat (2) @(posedge clk_o);
                #1ns rst_n_o = 1'b1; // Release just after the second edge
        end

endmodule

// ==== design/noc_router_switch.sv ====
`timescale 1ns/1ps

module noc_router_switch
        import noc_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n_i,
        input  flit_arr_t in_flit_i,
        input  logic      order_advance_i,
        output flit_arr_t out_flit_o,
        output req_vec_t  in_served_o
);

        req_mat_t req_mat;   // Requests per output port
        req_mat_t grant_mat; // Grants per output port

        route_decoder u_route_decoder (
                .in_flit_i (in_flit_i),
                .req_mat_o (req_mat)
        );

        // ############################################################
        // One arbiter per output, all sharing the order-advance strobe
        // ############################################################

        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
                rr_arbiter u_rr_arbiter (
                        .clk       (clk),
                        .rst_n_i   (rst_n_i),
                        .req_i     (req_mat[o]),
                        .advance_i (order_advance_i),
                        .grant_o   (grant_mat[o])
                );
        end

        crossbar_switch u_crossbar_switch (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .in_flit_i   (in_flit_i),
                .grant_mat_i (grant_mat),
                .out_flit_o  (out_flit_o),
                .in_served_o (in_served_o)
        );

endmodule

// ==== design/crossbar_switch.sv ====
`timescale 1ns/1ps

module crossbar_switch
        import noc_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n_i,
        input  flit_arr_t in_flit_i,
        input  req_mat_t  grant_mat_i,
        output flit_arr_t out_flit_o,
        output req_vec_t  in_served_o
);

        flit_arr_t sel_flit;
        flit_arr_t out_flit_q;
        req_vec_t  served;
        req_vec_t  served_q;

        // ############################################################
        // One-hot multiplexer per output
        // ############################################################

        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        sel_flit[o] = '0;
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                if (grant_mat_i[o][i]) begin
                                        sel_flit[o] = sel_flit[o] | in_flit_i[i];
                                end
                        end
                        sel_flit[o].valid = |grant_mat_i[o]; // Low when nobody won
                end
        end

        // An input is served if any output granted it
        always_comb begin
                served = '0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        served = served | grant_mat_i[o];
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        out_flit_q <= '0;
                        served_q   <= '0;
                end else begin
                        out_flit_q <= sel_flit;
                        served_q   <= served;
                end
        end

        assign out_flit_o  = out_flit_q;
        assign in_served_o = served_q;

endmodule

// ==== rr_arbiter/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter
        import noc_pkg::*;
(
        input  logic     clk,
        input  logic     rst_n_i,
        input  req_vec_t req_i,
        input  logic     advance_i,
        output req_vec_t grant_o
);

        port_id_t   ptr_q;    // Input that currently has top priority
        port_id_t   ptr_next;
        port_id_t   win_idx;
        port_id_t   scan_idx;
        logic [3:0] scan_sum;
        logic       found;

        // ############################################################
        // Grant search from the pointer upward, wrapping modulo 5
        // ############################################################

        always_comb begin
                grant_o  = '0;
                win_idx  = PORT_N;
                found    = 1'b0;
                scan_sum = '0;
                scan_idx = PORT_N;
                for (int k = 0; k < NUM_PORTS; k++) begin
                        scan_sum = {1'b0, ptr_q} + 4'(k);
                        if (scan_sum >= 4'(NUM_PORTS)) begin
                                scan_idx = port_id_t'(scan_sum - 4'(NUM_PORTS));
                        end else begin
                                scan_idx = port_id_t'(scan_sum);
                        end
                        if (!found && req_i[scan_idx]) begin
                                grant_o[scan_idx] = 1'b1;
                                win_idx           = scan_idx;
                                found             = 1'b1;
                        end
                end
        end

        // Winner goes to the back of the queue
        always_comb begin
                if (win_idx == PORT_L) begin
                        ptr_next = PORT_N;
                end else begin
                        ptr_next = win_idx + 3'd1;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        ptr_q <= PORT_N;
                end else if (advance_i && found) begin
                        ptr_q <= ptr_next; // Rotate only on the order-advance strobe
                end
        end

endmodule

// ==== design/route_decoder.sv ====
`timescale 1ns/1ps

module route_decoder
        import noc_pkg::*;
(
        input  flit_arr_t in_flit_i,
        output req_mat_t  req_mat_o
);

        req_vec_t dest_ok; // Next-hop number names a real port
        req_vec_t flit_vld;

        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        flit_vld[i] = in_flit_i[i].valid;
                        dest_ok[i]  = (in_flit_i[i].dest <= PORT_L);
                end
        end

        // ############################################################
        // Request matrix, rows are outputs and columns are inputs
        // ############################################################

        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                if (i == o) begin
                                        req_mat_o[o][i] = 1'b0; // A flit never turns back
                                end else begin
                                        req_mat_o[o][i] = flit_vld[i] && dest_ok[i] &&
                                                (in_flit_i[i].dest == port_id_t'(o));
                                end
                        end
                end
        end

endmodule

// ==== common/noc_pkg.sv ====
package noc_pkg;

        // ############################################################
        // Router dimensions
        // ############################################################

        localparam int unsigned NUM_PORTS = 5;
        localparam int unsigned PORT_ID_W = 3;
        localparam int unsigned PAYLOAD_W = 16;

        // ############################################################
        // Basic vector types
        // ############################################################

        typedef logic [PORT_ID_W-1:0] port_id_t; // Values 5 to 7 do not name a port
        typedef logic [PAYLOAD_W-1:0] payload_t;
        typedef logic [NUM_PORTS-1:0] req_vec_t; // One bit per input port

        // Port indices in mesh order
        localparam port_id_t PORT_N = 3'd0;
        localparam port_id_t PORT_S = 3'd1;
        localparam port_id_t PORT_W = 3'd2;
        localparam port_id_t PORT_E = 3'd3;
        localparam port_id_t PORT_L = 3'd4;

        // ############################################################
        // Flit and per-port bundles
        // ############################################################

        typedef struct packed {
                logic     valid;
                port_id_t dest;    // Next-hop output port
                payload_t payload;
        } flit_t;

        typedef flit_t [NUM_PORTS-1:0] flit_arr_t;   // Indexed by port
        typedef req_vec_t [NUM_PORTS-1:0] req_mat_t; // Indexed by output port

endpackage
